// File: flist.f
pmp_pkg.sv
pmp_csr_regs.sv
pmp_region_decode.sv
pmp_chan_check.sv
pmp_checker.sv
pmp_unit.sv
pmp_unit_assert.sv
tb_pmp_unit.sv

// File: pmp_chan_check.sv
/* PMP single-channel check */

module pmp_chan_check #(
  parameter int PMP_ENTRIES     = 8,
  parameter int PMP_GRANULARITY = 0
) (
  input  pmp_pkg::pmp_chan_req_t     req_i,
  input  logic                       priv_mode_ns_i,
  input  logic                       priv_mode_eff_i,
  input  pmp_pkg::mseccfg_t          mseccfg_i,
  input  pmp_pkg::pmp_cfg_t          pmpcfg_i [PMP_ENTRIES],
  input  logic [31:0]                pmpaddr_i [PMP_ENTRIES],
  input  logic [pmp_pkg::ADDR_W-1:0] start_addr_i [PMP_ENTRIES],
  input  logic [pmp_pkg::ADDR_W-1:0] addr_mask_i [PMP_ENTRIES],
  output logic                       err_o
);

  import pmp_pkg::*;

  localparam int LSB = PMP_GRANULARITY + 2;

  logic [ADDR_W-1:0]      req_addr;
  logic                   priv_mode;
  logic [PMP_ENTRIES-1:0] region_en;
  logic [PMP_ENTRIES-1:0] match_eq;
  logic [PMP_ENTRIES-1:0] match_gt;
  logic [PMP_ENTRIES-1:0] match_lt;
  logic [PMP_ENTRIES-1:0] match_all;
  logic [PMP_ENTRIES-1:0] basic_perm;
  logic [PMP_ENTRIES-1:0] perm_ok;

  // ----------------------------------------
  // Permission functions
  // ----------------------------------------

  // Classic PMP, lock bit only binds M-mode
  function automatic logic orig_perm_check(logic lock, logic priv, logic perm);
    return priv ? perm : (~lock | perm);
  endfunction

  // Smepmp rules while mml is set
  function automatic logic mml_perm_check(pmp_cfg_t cfg, pmp_req_e req, logic priv,
                                          logic perm);
    logic result;
    if (!cfg.read && cfg.write) begin
      // Shared regions, L and X pick the sharing
      unique case ({cfg.lock, cfg.execute})
        // RW in M, R in U
        2'b00: result = (req == READ) | ((req == WRITE) & ~priv);
        // RW in both
        2'b01: result = (req == READ) | (req == WRITE);
        // X in both
        2'b10: result = (req == EXEC);
        // RX in M, X in U
        2'b11: result = (req == EXEC) | ((req == READ) & ~priv);
      endcase
    end else if (cfg.read && cfg.write && cfg.execute && cfg.lock) begin
      // Read-only shared region
      result = (req == READ);
    end else begin
      // L set means M-only, L clear means U-only
      result = perm & (priv ? ~cfg.lock : cfg.lock);
    end
    return result;
  endfunction

  // Lowest matching entry wins, default-deny otherwise
  function automatic logic access_fault_check(mseccfg_t msec, pmp_req_e req, logic priv,
                                              logic any_en,
                                              logic [PMP_ENTRIES-1:0] match,
                                              logic [PMP_ENTRIES-1:0] perm);
    logic fail;
    logic matched;
    fail    = msec.mmwp | (priv & any_en) | (msec.mml & (req == EXEC));
    matched = 1'b0;
    for (int r = 0; r < PMP_ENTRIES; r++) begin
      if (!matched && match[r]) begin
        fail    = ~perm[r];
        matched = 1'b1;
      end
    end
    return fail;
  endfunction

  // ----------------------------------------
  // Per-entry matching
  // ----------------------------------------

  assign req_addr = {2'b00, req_i.addr};

  // Fetch uses next-cycle mode, loads and stores see MPRV
  assign priv_mode = (req_i.req_type == EXEC) ? priv_mode_ns_i : priv_mode_eff_i;

  for (genvar r = 0; r < PMP_ENTRIES; r++) begin : g_entry
    logic [ADDR_W-1:0] end_addr;

    assign end_addr     = {pmpaddr_i[r], 2'b00};
    assign region_en[r] = (pmpcfg_i[r].mode != OFF);

    // Mask already zeroes the bits inside the granule
    assign match_eq[r] = ((req_addr & addr_mask_i[r]) ==
                          (start_addr_i[r] & addr_mask_i[r]));
    assign match_gt[r] = req_addr[ADDR_W-1:LSB] > start_addr_i[r][ADDR_W-1:LSB];
    assign match_lt[r] = req_addr[ADDR_W-1:LSB] < end_addr[ADDR_W-1:LSB];

    always_comb begin
      match_all[r] = 1'b0;
      unique case (pmpcfg_i[r].mode)
        OFF:   match_all[r] = 1'b0;
        TOR:   match_all[r] = (match_eq[r] | match_gt[r]) & match_lt[r];
        NA4:   match_all[r] = match_eq[r];
        NAPOT: match_all[r] = match_eq[r];
      endcase
    end

    // Plain R/W/X bit for the request type
    assign basic_perm[r] = ((req_i.req_type == READ)  & pmpcfg_i[r].read) |
                           ((req_i.req_type == WRITE) & pmpcfg_i[r].write) |
                           ((req_i.req_type == EXEC)  & pmpcfg_i[r].execute);

    assign perm_ok[r] = mseccfg_i.mml ?
        mml_perm_check(pmpcfg_i[r], req_i.req_type, priv_mode, basic_perm[r]) :
        orig_perm_check(pmpcfg_i[r].lock, priv_mode, basic_perm[r]);
  end

  assign err_o = access_fault_check(mseccfg_i, req_i.req_type, priv_mode, |region_en,
                                    match_all, perm_ok);

endmodule

// File: pmp_checker.sv
/* PMP access checker */

module pmp_checker #(
  parameter int PMP_ENTRIES     = 8,
  parameter int PMP_CHANNELS    = 3,
  parameter int PMP_GRANULARITY = 0
) (
  input  pmp_pkg::pmp_cfg_t      pmpcfg_i [PMP_ENTRIES],
  input  logic [31:0]            pmpaddr_i [PMP_ENTRIES],
  input  pmp_pkg::mseccfg_t      mseccfg_i,
  input  logic                   priv_mode_ns_i,
  input  logic                   priv_mode_eff_i,
  input  pmp_pkg::pmp_chan_req_t chan_req_i [PMP_CHANNELS],
  output logic [PMP_CHANNELS-1:0] chan_err_o
);

  import pmp_pkg::*;

  logic [ADDR_W-1:0] start_addr [PMP_ENTRIES];
  logic [ADDR_W-1:0] addr_mask [PMP_ENTRIES];

  // One decoder per entry, shared by all channels
  for (genvar r = 0; r < PMP_ENTRIES; r++) begin : g_region
    localparam int PREV = (r == 0) ? 0 : r - 1;

    pmp_region_decode #(
      .PMP_GRANULARITY(PMP_GRANULARITY),
      .IS_FIRST       (r == 0)
    ) region_decode_i (
      .cfg_i       (pmpcfg_i[r]),
      .addr_i      (pmpaddr_i[r]),
      .prev_addr_i (pmpaddr_i[PREV]),
      .start_addr_o(start_addr[r]),
      .addr_mask_o (addr_mask[r])
    );
  end

  // Independent check per channel
  for (genvar c = 0; c < PMP_CHANNELS; c++) begin : g_chan
    pmp_chan_check #(
      .PMP_ENTRIES    (PMP_ENTRIES),
      .PMP_GRANULARITY(PMP_GRANULARITY)
    ) chan_check_i (
      .req_i          (chan_req_i[c]),
      .priv_mode_ns_i (priv_mode_ns_i),
      .priv_mode_eff_i(priv_mode_eff_i),
      .mseccfg_i      (mseccfg_i),
      .pmpcfg_i       (pmpcfg_i),
      .pmpaddr_i      (pmpaddr_i),
      .start_addr_i   (start_addr),
      .addr_mask_i    (addr_mask),
      .err_o          (chan_err_o[c])
    );
  end

endmodule

// File: pmp_csr_regs.sv
/* PMP register file */

module pmp_csr_regs #(
  parameter int PMP_ENTRIES = 8
) (
  input  logic                 clk,
  input  logic                 rst_i,
  input  pmp_pkg::pmp_csr_wr_t csr_wr_i,
  output pmp_pkg::pmp_cfg_t    pmpcfg_o [PMP_ENTRIES],
  output logic [31:0]          pmpaddr_o [PMP_ENTRIES],
  output pmp_pkg::mseccfg_t    mseccfg_o
);

  import pmp_pkg::*;

  pmp_cfg_t    pmpcfg_q [PMP_ENTRIES];
  logic [31:0] pmpaddr_q [PMP_ENTRIES];
  mseccfg_t    mseccfg_q;

  logic [PMP_ENTRIES-1:0] lock_bit;
  logic [PMP_ENTRIES-1:0] locked;
  logic [PMP_ENTRIES-1:0] tor_locked;
  logic [PMP_ENTRIES-1:0] cfg_we;
  logic [PMP_ENTRIES-1:0] addr_we;
  logic                   msec_we;
  mseccfg_t               msec_wdata;

  // ----------------------------------------
  // Write enables
  // ----------------------------------------

  for (genvar i = 0; i < PMP_ENTRIES; i++) begin : g_entry_we
    assign lock_bit[i] = pmpcfg_q[i].lock;
    // RLB lifts the lock without clearing it
    assign locked[i] = pmpcfg_q[i].lock & ~mseccfg_q.rlb;

    // Locked TOR entry above freezes this address, it is the region base
    if (i < PMP_ENTRIES - 1) begin : g_next
      assign tor_locked[i] = locked[i+1] & (pmpcfg_q[i+1].mode == TOR);
    end else begin : g_last
      assign tor_locked[i] = 1'b0;
    end

    // Indices past the last entry never decode, so such writes drop
    assign cfg_we[i]  = csr_wr_i.we & (csr_wr_i.sel == SEL_CFG) &
                        (csr_wr_i.idx == 4'(i)) & ~locked[i];
    assign addr_we[i] = csr_wr_i.we & (csr_wr_i.sel == SEL_ADDR) &
                        (csr_wr_i.idx == 4'(i)) & ~locked[i] & ~tor_locked[i];
  end

  assign msec_we    = csr_wr_i.we & (csr_wr_i.sel == SEL_MSECCFG);
  assign msec_wdata = mseccfg_t'(csr_wr_i.wdata[2:0]);

  // ----------------------------------------
  // State
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < PMP_ENTRIES; i++) begin
        pmpcfg_q[i]  <= '0;
        pmpaddr_q[i] <= '0;
      end
      mseccfg_q <= '0;
    end else begin
      for (int i = 0; i < PMP_ENTRIES; i++) begin
        if (cfg_we[i]) begin
          pmpcfg_q[i] <= pmp_cfg_t'(csr_wr_i.wdata[7:0]);
        end
        if (addr_we[i]) begin
          pmpaddr_q[i] <= csr_wr_i.wdata;
        end
      end
      if (msec_we) begin
        // Sticky bits, only reset clears them
        mseccfg_q.mml  <= mseccfg_q.mml | msec_wdata.mml;
        mseccfg_q.mmwp <= mseccfg_q.mmwp | msec_wdata.mmwp;
        // Once any lock bit exists RLB may only fall
        if (|lock_bit) begin
          mseccfg_q.rlb <= mseccfg_q.rlb & msec_wdata.rlb;
        end else begin
          mseccfg_q.rlb <= msec_wdata.rlb;
        end
      end
    end
  end

  assign pmpcfg_o  = pmpcfg_q;
  assign pmpaddr_o = pmpaddr_q;
  assign mseccfg_o = mseccfg_q;

endmodule

// File: pmp_pkg.sv
/* PMP shared types */

package pmp_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------

  // Internal byte address, word address shifted left by two
  localparam int ADDR_W = 34;

  // ----------------------------------------
  // Configuration
  // ----------------------------------------

  // Address-matching mode of one entry
  typedef enum logic [1:0] {
    OFF   = 2'b00,
    TOR   = 2'b01,
    NA4   = 2'b10,
    NAPOT = 2'b11
  } pmp_mode_e;

  // One pmpcfg byte, same bit order as the spec
  typedef struct packed {
    logic      lock;
    logic [1:0] reserved;
    pmp_mode_e mode;
    logic      execute;
    logic      write;
    logic      read;
  } pmp_cfg_t;

  // Machine security config, bit 0 is mml as in the CSR
  typedef struct packed {
    logic rlb;
    logic mmwp;
    logic mml;
  } mseccfg_t;

  // ----------------------------------------
  // Register write port
  // ----------------------------------------

  typedef enum logic [1:0] {
    SEL_CFG     = 2'b00,
    SEL_ADDR    = 2'b01,
    SEL_MSECCFG = 2'b10
  } csr_sel_e;

  // Single-cycle write strobe with entry index
  typedef struct packed {
    logic        we;
    csr_sel_e    sel;
    logic [3:0]  idx;
    logic [31:0] wdata;
  } pmp_csr_wr_t;

  // ----------------------------------------
  // Access requests
  // ----------------------------------------

  typedef enum logic [1:0] {
    READ  = 2'b00,
    WRITE = 2'b01,
    EXEC  = 2'b10
  } pmp_req_e;

  // Privilege inputs use 1 for U-mode and 0 for M-mode
  typedef struct packed {
    logic [31:0] addr;
    pmp_req_e    req_type;
  } pmp_chan_req_t;

endpackage

// File: pmp_region_decode.sv
/* PMP region decoder */

module pmp_region_decode #(
  parameter int PMP_GRANULARITY = 0,
  parameter bit IS_FIRST        = 1'b0
) (
  input  pmp_pkg::pmp_cfg_t          cfg_i,
  input  logic [31:0]                addr_i,
  input  logic [31:0]                prev_addr_i,
  output logic [pmp_pkg::ADDR_W-1:0] start_addr_o,
  output logic [pmp_pkg::ADDR_W-1:0] addr_mask_o
);

  import pmp_pkg::*;

  // Lowest bit that takes part in a compare
  localparam int LSB = PMP_GRANULARITY + 2;
  // Lowest address bit scanned for trailing ones
  localparam int MLO = (PMP_GRANULARITY == 0) ? 2 : PMP_GRANULARITY + 1;

  logic [ADDR_W-1:0] addr_byte;
  logic [ADDR_W-1:0] tor_base;
  logic              is_napot;

  // Word address to byte address
  assign addr_byte = {addr_i, 2'b00};
  assign is_napot  = (cfg_i.mode == NAPOT);

  // TOR base is the entry below, or zero for entry 0
  assign tor_base     = IS_FIRST ? '0 : {prev_addr_i, 2'b00};
  assign start_addr_o = (cfg_i.mode == TOR) ? tor_base : addr_byte;

  // ----------------------------------------
  // NAPOT mask
  // ----------------------------------------

  for (genvar b = 0; b < ADDR_W; b++) begin : g_mask
    if (b < LSB) begin : g_below
      // Inside the granule, never compared
      assign addr_mask_o[b] = 1'b0;
    end else if (b == 2) begin : g_bit2
      // NAPOT is at least 8 bytes, so bit 2 is always masked
      assign addr_mask_o[b] = ~is_napot;
    end else begin : g_upper
      // Masked when every lower address bit is one
      // e.g. yyyy0111 gives mask 11110000
      assign addr_mask_o[b] = ~is_napot | ~&addr_byte[b-1:MLO];
    end
  end

endmodule

// File: pmp_unit.sv
/* PMP unit top level */

module pmp_unit #(
  parameter int PMP_ENTRIES     = 8,
  parameter int PMP_CHANNELS    = 3,
  parameter int PMP_GRANULARITY = 0
) (
  input  logic                    clk,
  input  logic                    rst_i,
  input  pmp_pkg::pmp_csr_wr_t    csr_wr_i,
  input  logic                    priv_mode_ns_i,
  input  logic                    priv_mode_eff_i,
  input  pmp_pkg::pmp_chan_req_t  chan_req_i [PMP_CHANNELS],
  output logic [PMP_CHANNELS-1:0] chan_err_o
);

  import pmp_pkg::*;

  pmp_cfg_t    pmpcfg [PMP_ENTRIES];
  logic [31:0] pmpaddr [PMP_ENTRIES];
  mseccfg_t    mseccfg;

  // Register state, written on the strobe
  pmp_csr_regs #(
    .PMP_ENTRIES(PMP_ENTRIES)
  ) csr_regs_i (
    .clk      (clk),
    .rst_i    (rst_i),
    .csr_wr_i (csr_wr_i),
    .pmpcfg_o (pmpcfg),
    .pmpaddr_o(pmpaddr),
    .mseccfg_o(mseccfg)
  );

  // Combinational check, zero latency
  pmp_checker #(
    .PMP_ENTRIES    (PMP_ENTRIES),
    .PMP_CHANNELS   (PMP_CHANNELS),
    .PMP_GRANULARITY(PMP_GRANULARITY)
  ) checker_i (
    .pmpcfg_i       (pmpcfg),
    .pmpaddr_i      (pmpaddr),
    .mseccfg_i      (mseccfg),
    .priv_mode_ns_i (priv_mode_ns_i),
    .priv_mode_eff_i(priv_mode_eff_i),
    .chan_req_i     (chan_req_i),
    .chan_err_o     (chan_err_o)
  );

endmodule

// File: pmp_unit_assert.sv
/* PMP unit assertions */

module pmp_unit_assert #(
  parameter int PMP_ENTRIES  = 8,
  parameter int PMP_CHANNELS = 3
) (
  input logic                    clk,
  input logic                    rst_i,
  input pmp_pkg::pmp_cfg_t       pmpcfg_i [PMP_ENTRIES],
  input pmp_pkg::mseccfg_t       mseccfg_i,
  input logic [PMP_CHANNELS-1:0] chan_err_i
);

  import pmp_pkg::*;

  logic all_off;

  always_comb begin
    all_off = 1'b1;
    for (int i = 0; i < PMP_ENTRIES; i++) begin
      if (pmpcfg_i[i].mode != OFF) all_off = 1'b0;
    end
  end

  // No entries and no mseccfg bits, nothing can fault
  a_off_no_err: assert property (@(posedge clk) disable iff (rst_i)
    (all_off && mseccfg_i == '0) |-> (chan_err_i == '0))
    else $error("fault with all entries off");

  // mml is sticky
  a_mml_sticky: assert property (@(posedge clk) disable iff (rst_i)
    (!$past(rst_i) && $past(mseccfg_i.mml)) |-> mseccfg_i.mml)
    else $error("mml cleared outside reset");

  a_err_known: assert property (@(posedge clk) disable iff (rst_i)
    !$isunknown(chan_err_i))
    else $error("chan_err_o unknown");

endmodule

bind pmp_unit pmp_unit_assert #(
  .PMP_ENTRIES (PMP_ENTRIES),
  .PMP_CHANNELS(PMP_CHANNELS)
) assert_i (
  .clk       (clk),
  .rst_i     (rst_i),
  .pmpcfg_i  (pmpcfg),
  .mseccfg_i (mseccfg),
  .chan_err_i(chan_err_o)
);

// File: run.sh
#!/bin/sh
# Build and run the PMP unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert --top-module tb_pmp_unit -f flist.f \
  --Mdir obj_dir -o sim_tb > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "^TB PASSED$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: tb_pmp_unit.sv
/* PMP unit testbench */

module tb_pmp_unit;

  import pmp_pkg::*;

  localparam int N_ENTRIES = 8;
  localparam int N_CHAN    = 3;

  logic              clk;
  logic              rst_i;
  pmp_csr_wr_t       csr_wr;
  logic              priv_ns;
  logic              priv_eff;
  pmp_chan_req_t     chan_req [N_CHAN];
  logic [N_CHAN-1:0] chan_err;

  // Shadow of the register state, updated by the write rules
  pmp_cfg_t    sh_cfg [N_ENTRIES];
  logic [31:0] sh_addr [N_ENTRIES];
  mseccfg_t    sh_msec;

  logic  chk_en;
  int    n_err;
  int    n_checks;
  int    test_err0;
  string test_name;

  pmp_unit #(
    .PMP_ENTRIES    (N_ENTRIES),
    .PMP_CHANNELS   (N_CHAN),
    .PMP_GRANULARITY(0)
  ) dut_i (
    .clk            (clk),
    .rst_i          (rst_i),
    .csr_wr_i       (csr_wr),
    .priv_mode_ns_i (priv_ns),
    .priv_mode_eff_i(priv_eff),
    .chan_req_i     (chan_req),
    .chan_err_o     (chan_err)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  function automatic logic rwx_bit(logic [2:0] rwx, pmp_req_e req);
    if (req == READ) return rwx[2];
    if (req == WRITE) return rwx[1];
    return rwx[0];
  endfunction

  // Smepmp table, index {L,R,W,X}, value {M rwx, U rwx}
  function automatic logic mml_allow(pmp_cfg_t cfg, pmp_req_e req, logic priv);
    logic [5:0] tbl;
    case ({cfg.lock, cfg.read, cfg.write, cfg.execute})
      4'b0001: tbl = 6'b000_001;
      4'b0010: tbl = 6'b110_100;
      4'b0011: tbl = 6'b110_110;
      4'b0100: tbl = 6'b000_100;
      4'b0101: tbl = 6'b000_101;
      4'b0110: tbl = 6'b000_110;
      4'b0111: tbl = 6'b000_111;
      4'b1001: tbl = 6'b001_000;
      4'b1010: tbl = 6'b001_001;
      4'b1011: tbl = 6'b101_001;
      4'b1100: tbl = 6'b100_000;
      4'b1101: tbl = 6'b101_000;
      4'b1110: tbl = 6'b110_000;
      4'b1111: tbl = 6'b100_100;
      default: tbl = 6'b000_000;
    endcase
    return rwx_bit(priv ? tbl[2:0] : tbl[5:3], req);
  endfunction

  function automatic logic pmp_ref_err(pmp_chan_req_t req, logic ns, logic eff);
    logic        priv;
    logic        any_en;
    logic        hit;
    logic        perm;
    logic [33:0] a;
    logic [33:0] lo;
    int          t;
    priv   = (req.req_type == EXEC) ? ns : eff;
    a      = {2'b00, req.addr};
    any_en = 1'b0;
    for (int i = 0; i < N_ENTRIES; i++) begin
      if (sh_cfg[i].mode != OFF) any_en = 1'b1;
    end
    for (int i = 0; i < N_ENTRIES; i++) begin
      hit = 1'b0;
      case (sh_cfg[i].mode)
        NA4: hit = (a[33:2] == sh_addr[i]);
        NAPOT: begin
          // Region size follows the trailing ones of the word address
          t = 0;
          while (t < 32 && sh_addr[i][t]) t++;
          if (t + 3 >= 34) hit = 1'b1;
          else hit = ((a >> (t + 3)) == ({sh_addr[i], 2'b00} >> (t + 3)));
        end
        TOR: begin
          if (i == 0) lo = '0;
          else lo = {sh_addr[i-1], 2'b00};
          hit = (a >= lo) && (a < {sh_addr[i], 2'b00});
        end
        default: hit = 1'b0;
      endcase
      if (hit) begin
        perm = rwx_bit({sh_cfg[i].read, sh_cfg[i].write, sh_cfg[i].execute}, req.req_type);
        if (sh_msec.mml) return !mml_allow(sh_cfg[i], req.req_type, priv);
        if (priv) return !perm;
        return sh_cfg[i].lock && !perm;
      end
    end
    // No match, default-deny rules
    return sh_msec.mmwp | (priv & any_en) | (sh_msec.mml & (req.req_type == EXEC));
  endfunction

  function automatic logic ent_locked(int i);
    return sh_cfg[i].lock && !sh_msec.rlb;
  endfunction

  task automatic apply_write(pmp_csr_wr_t wr);
    int   i;
    logic any_lock;
    logic tor_blk;
    i        = int'(wr.idx);
    any_lock = 1'b0;
    tor_blk  = 1'b0;
    for (int j = 0; j < N_ENTRIES; j++) any_lock |= sh_cfg[j].lock;
    if (i + 1 < N_ENTRIES) tor_blk = ent_locked(i + 1) && (sh_cfg[i+1].mode == TOR);
    case (wr.sel)
      SEL_CFG: if (i < N_ENTRIES && !ent_locked(i)) sh_cfg[i] = pmp_cfg_t'(wr.wdata[7:0]);
      SEL_ADDR: if (i < N_ENTRIES && !ent_locked(i) && !tor_blk) sh_addr[i] = wr.wdata;
      SEL_MSECCFG: begin
        sh_msec.mml  = sh_msec.mml | wr.wdata[0];
        sh_msec.mmwp = sh_msec.mmwp | wr.wdata[1];
        sh_msec.rlb  = any_lock ? (sh_msec.rlb & wr.wdata[2]) : wr.wdata[2];
      end
      default: ;
    endcase
  endtask

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------

  task automatic check_err(int ch, pmp_chan_req_t req, logic got, logic exp);
    n_checks++;
    if (got !== exp) begin
      n_err++;
      $display("MISMATCH t=%0t ch%0d addr=%h type=%0d got=%b exp=%b",
               $time, ch, req.addr, req.req_type, got, exp);
    end
  endtask

  // Expected cfg checked through M-mode probes at an address it owns
  task automatic check_cfg(int idx, pmp_cfg_t exp, logic [31:0] probe);
    logic exp_err;
    n_checks++;
    if (sh_cfg[idx] !== exp) begin
      n_err++;
      $display("MISMATCH t=%0t cfg%0d held=%h expected=%h", $time, idx, sh_cfg[idx], exp);
    end
    priv_ns  = 1'b0;
    priv_eff = 1'b0;
    for (int k = 0; k < 3; k++) begin
      chan_req[0] = make_req(probe, pmp_req_e'(2'(k)));
      exp_err = exp.lock & ~rwx_bit({exp.read, exp.write, exp.execute}, chan_req[0].req_type);
      tick();
      #1;
      check_err(0, chan_req[0], chan_err[0], exp_err);
    end
  endtask

  // Samples just before each rising edge
  initial begin : compare
    forever begin
      @(posedge clk);
      #3;
      if (chk_en) begin
        for (int c = 0; c < N_CHAN; c++) begin
          check_err(c, chan_req[c], chan_err[c], pmp_ref_err(chan_req[c], priv_ns, priv_eff));
        end
      end
    end
  end

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  function automatic pmp_chan_req_t make_req(logic [31:0] a, pmp_req_e t);
    pmp_chan_req_t r;
    r.addr     = a;
    r.req_type = t;
    return r;
  endfunction

  function automatic pmp_cfg_t make_cfg(logic l, pmp_mode_e m, logic x, logic w, logic r);
    pmp_cfg_t c;
    c         = '0;
    c.lock    = l;
    c.mode    = m;
    c.execute = x;
    c.write   = w;
    c.read    = r;
    return c;
  endfunction

  // Half fully random, half near a programmed address
  function automatic logic [31:0] pick_addr();
    int k;
    if ($urandom_range(1, 0) == 0) return $urandom;
    k = int'($urandom_range(N_ENTRIES - 1, 0));
    return {sh_addr[k][29:0], 2'b00} + 32'($urandom_range(63, 0)) - 32'd32;
  endfunction

  task automatic drive_random();
    priv_ns  = 1'($urandom_range(1, 0));
    priv_eff = 1'($urandom_range(1, 0));
    for (int c = 0; c < N_CHAN; c++) begin
      chan_req[c] = make_req(pick_addr(), pmp_req_e'(2'($urandom_range(2, 0))));
    end
  endtask

  task automatic write_csr(csr_sel_e sel, int idx, logic [31:0] data);
    csr_wr.we    = 1'b1;
    csr_wr.sel   = sel;
    csr_wr.idx   = 4'(idx);
    csr_wr.wdata = data;
    tick();
    apply_write(csr_wr);
    csr_wr.we = 1'b0;
  endtask

  task automatic write_cfg(int idx, pmp_cfg_t c);
    write_csr(SEL_CFG, idx, {24'h0, c});
  endtask

  task automatic reset_dut(output logic ok);
    int cnt;
    chk_en    = 1'b0;
    rst_i     = 1'b1;
    csr_wr.we = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst_i = 1'b0;
    for (int i = 0; i < N_ENTRIES; i++) begin
      sh_cfg[i]  = '0;
      sh_addr[i] = '0;
    end
    sh_msec = '0;
    // Outputs must settle to known values
    cnt = 0;
    while ($isunknown(chan_err) && cnt < 8) begin
      tick();
      cnt++;
    end
    ok = !$isunknown(chan_err);
    if (!ok) begin
      n_err++;
      $display("Error at t=%0t: chan_err_o still unknown 8 cycles after reset", $time);
    end
    chk_en = ok;
  endtask

  task automatic begin_test(string name);
    test_name = name;
    test_err0 = n_err;
  endtask

  task automatic end_test();
    $display("test %s done, %0d errors", test_name, n_err - test_err0);
  endtask

  task automatic end_run();
    $display("checks %0d, errors %0d", n_checks, n_err);
    if (n_err == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------

  task automatic test_regions();
    logic ok;
    for (int round = 0; round < 4; round++) begin
      reset_dut(ok);
      // Addresses first, a lock bit would freeze them
      for (int i = 0; i < 6; i++) begin
        write_csr(SEL_ADDR, i, 32'h400 + 32'(i * 64) + $urandom_range(63, 0));
      end
      for (int i = 0; i < 6; i++) write_csr(SEL_CFG, i, $urandom & 32'h9f);
      repeat (40) begin
        drive_random();
        tick();
      end
    end
  endtask

  task automatic test_lock();
    logic     ok;
    pmp_cfg_t c0;
    pmp_cfg_t c1;
    pmp_cfg_t c3;
    reset_dut(ok);
    c0 = make_cfg(1'b1, NA4, 1'b0, 1'b0, 1'b1);
    write_csr(SEL_ADDR, 0, 32'h400);
    write_cfg(0, c0);
    // Both writes dropped, entry is locked
    write_cfg(0, make_cfg(1'b0, NA4, 1'b1, 1'b1, 1'b1));
    write_csr(SEL_ADDR, 0, 32'h500);
    check_cfg(0, c0, 32'h1000);
    // Locked TOR freezes the base below it
    write_csr(SEL_ADDR, 2, 32'h600);
    write_csr(SEL_ADDR, 3, 32'h700);
    c3 = make_cfg(1'b1, TOR, 1'b0, 1'b0, 1'b1);
    write_cfg(3, c3);
    write_csr(SEL_ADDR, 2, 32'h680);
    check_cfg(3, c3, 32'h1900);
    chan_req[1] = make_req(32'h800, WRITE);
    tick();
    // Unlocked NAPOT, 32 bytes at 0x1200
    c1 = make_cfg(1'b0, NAPOT, 1'b0, 1'b0, 1'b0);
    write_csr(SEL_ADDR, 1, 32'h483);
    write_cfg(1, c1);
    check_cfg(1, c1, 32'h1210);
    priv_eff    = 1'b1;
    priv_ns     = 1'b1;
    chan_req[0] = make_req(32'h1210, READ);
    chan_req[1] = make_req(32'h1214, EXEC);
    repeat (2) tick();
  endtask

  task automatic test_mml();
    logic       ok;
    logic [3:0] lrwx;
    reset_dut(ok);
    // RLB keeps entry 0 writable across the table
    write_csr(SEL_MSECCFG, 0, 32'h5);
    write_csr(SEL_ADDR, 0, 32'h400);
    for (int combo = 0; combo < 16; combo++) begin
      lrwx = 4'(combo);
      write_cfg(0, make_cfg(lrwx[3], NA4, lrwx[0], lrwx[1], lrwx[2]));
      for (int p = 0; p < 2; p++) begin
        for (int k = 0; k < 3; k++) begin
          priv_ns     = 1'(p);
          priv_eff    = 1'(p);
          chan_req[0] = make_req(32'h1000, pmp_req_e'(2'(k)));
          chan_req[1] = make_req(32'h8000, EXEC);
          chan_req[2] = make_req(32'h1003, pmp_req_e'(2'((k + 1) % 3)));
          tick();
        end
      end
    end
    // Clear attempt, mml must stay set
    write_csr(SEL_MSECCFG, 0, 32'h0);
    priv_ns = 1'b0;
    for (int c = 0; c < N_CHAN; c++) chan_req[c] = make_req(32'h9000 + 32'(c), EXEC);
    repeat (4) tick();
  endtask

  task automatic test_mmwp_rlb();
    logic     ok;
    pmp_cfg_t cb;
    reset_dut(ok);
    write_csr(SEL_MSECCFG, 0, 32'h2);
    write_csr(SEL_MSECCFG, 0, 32'h0);
    repeat (20) begin
      drive_random();
      priv_ns  = 1'b0;
      priv_eff = 1'b0;
      tick();
    end
    reset_dut(ok);
    write_csr(SEL_MSECCFG, 0, 32'h4);
    write_csr(SEL_ADDR, 0, 32'h400);
    write_cfg(0, make_cfg(1'b1, NA4, 1'b0, 1'b0, 1'b1));
    cb = make_cfg(1'b1, NA4, 1'b0, 1'b1, 1'b1);
    write_cfg(0, cb);
    check_cfg(0, cb, 32'h1000);
    // Drop rlb, then it can no longer come back
    write_csr(SEL_MSECCFG, 0, 32'h0);
    write_csr(SEL_MSECCFG, 0, 32'h4);
    write_cfg(0, make_cfg(1'b0, NA4, 1'b1, 1'b1, 1'b1));
    check_cfg(0, cb, 32'h1000);
  endtask

  initial begin : main
    logic ok;
    void'($urandom(15));
    rst_i     = 1'b1;
    csr_wr    = '0;
    priv_ns   = 1'b0;
    priv_eff  = 1'b0;
    chk_en    = 1'b0;
    n_err     = 0;
    n_checks  = 0;
    for (int c = 0; c < N_CHAN; c++) chan_req[c] = '0;
    reset_dut(ok);
    if (ok) begin
      begin_test("reset_clean");
      repeat (60) begin
        drive_random();
        tick();
      end
      end_test();
      begin_test("regions");
      test_regions();
      end_test();
      begin_test("lock");
      test_lock();
      end_test();
      begin_test("mml");
      test_mml();
      end_test();
      begin_test("mmwp_rlb");
      test_mmwp_rlb();
      end_test();
    end
    end_run();
  end

endmodule
